//--- common/rv32i_types_pkg.sv
// ======================================
// RV32I word and register index types
// Fetch address after reset
// ======================================

package rv32i_types_pkg;

    localparam int WORD_W    = 32;  // XLEN for RV32
    localparam int REG_IDX_W = 5;   // x0..x31
    localparam int PC_STEP   = 4;   // No compressed instructions

    // Machine word, used for PCs, addresses and CSR data
    typedef logic [WORD_W-1:0] word_t;

    // Architectural register index
    typedef logic [REG_IDX_W-1:0] regidx_t;

    // First fetch after reset
    localparam word_t RESET_PC = 32'h0000_0200;

endpackage

//--- common/pipe_ctrl_pkg.sv
// ======================================
// Trap cause codes and trap vector
// Exception flag positions and priority
// ======================================

package pipe_ctrl_pkg;

    import rv32i_types_pkg::*;

    localparam int CAUSE_W       = 4;
    localparam int MCAUSE_IRQ_B  = 31;               // Interrupt flag in mcause
    localparam word_t TRAP_VECTOR = 32'h0000_0100;   // mtvec, direct mode only

    // Exception codes, RISC-V numbering
    typedef enum logic [CAUSE_W-1:0] {
        CAUSE_MAL_INSN   = 4'd0,
        CAUSE_FAULT_INSN = 4'd1,
        CAUSE_ILLEGAL    = 4'd2,
        CAUSE_BREAKPOINT = 4'd3,
        CAUSE_MAL_L      = 4'd4,
        CAUSE_FAULT_L    = 4'd5,
        CAUSE_MAL_S      = 4'd6,
        CAUSE_FAULT_S    = 4'd7,
        CAUSE_ECALL_M    = 4'd11
    } cause_t;

    localparam logic [CAUSE_W-1:0] IRQ_EXT_CAUSE = 4'd11;  // Machine external irq

    // Flag positions, higher index wins
    localparam int EXC_COUNT      = 9;
    localparam int EXC_BREAKPOINT = 8;
    localparam int EXC_FAULT_INSN = 7;
    localparam int EXC_MAL_INSN   = 6;
    localparam int EXC_ILLEGAL    = 5;
    localparam int EXC_ENV        = 4;
    localparam int EXC_MAL_S      = 3;
    localparam int EXC_MAL_L      = 2;
    localparam int EXC_FAULT_S    = 1;
    localparam int EXC_FAULT_L    = 0;

    // Flag position to architectural cause
    function automatic cause_t exc_cause(input int idx);
        case (idx)
            EXC_BREAKPOINT: return CAUSE_BREAKPOINT;
            EXC_FAULT_INSN: return CAUSE_FAULT_INSN;
            EXC_MAL_INSN:   return CAUSE_MAL_INSN;
            EXC_ENV:        return CAUSE_ECALL_M;
            EXC_MAL_S:      return CAUSE_MAL_S;
            EXC_MAL_L:      return CAUSE_MAL_L;
            EXC_FAULT_S:    return CAUSE_FAULT_S;
            EXC_FAULT_L:    return CAUSE_FAULT_L;
            default:        return CAUSE_ILLEGAL;
        endcase
    endfunction

    // Causes that report the faulting address in mtval
    function automatic logic is_addr_fault(input cause_t c);
        return c inside {CAUSE_MAL_INSN, CAUSE_FAULT_INSN, CAUSE_MAL_L,
                         CAUSE_FAULT_L, CAUSE_MAL_S, CAUSE_FAULT_S};
    endfunction

endpackage

//--- hazard/stage3_hazard_unit.sv
// ======================================
// Stall, flush and PC enable for F/E, E/M
// Exception PC and trap notification
// ======================================

`timescale 1ns/1ps

module stage3_hazard_unit
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;
(
    // Register dependencies
    input  regidx_t              rs1_e,
    input  regidx_t              rs2_e,
    input  regidx_t              rd_m,
    input  logic                 reg_write_m,
    // Stage status
    input  logic                 dren,
    input  logic                 dwen,
    input  logic                 csr_read,
    input  logic                 jump,
    input  logic                 branch,
    input  logic                 mispredict,
    input  logic                 i_mem_busy,
    input  logic                 d_mem_busy,
    input  logic                 ex_busy,
    input  logic                 ifence,
    input  logic                 fence_stall,
    input  logic                 halt,
    input  logic                 mret,
    // From trap block
    input  logic                 intr,
    input  logic                 insert_pc,
    input  word_t                priv_pc_in,
    // Exceptions
    input  logic [EXC_COUNT-1:0] exc_flags,
    input  word_t                fault_addr,
    // From PC chain
    input  word_t                pc_f,
    input  word_t                pc_e,
    input  word_t                pc_m,
    input  logic                 valid_e,
    input  logic                 valid_m,
    // Pipeline controls
    output logic                 pc_en,
    output logic                 npc_sel,
    output logic                 if_ex_stall,
    output logic                 if_ex_flush,
    output logic                 ex_mem_stall,
    output logic                 ex_mem_flush,
    output logic                 mem_use_stall,
    output logic                 suppress_iren,
    output logic                 suppress_data,
    output logic                 rollback,
    // To trap block
    output logic                 wb_enable,
    output logic [EXC_COUNT-1:0] exc_masked,
    output word_t                epc,
    output word_t                badaddr,
    // Redirect towards fetch
    output logic                 insert_priv_pc,
    output word_t                priv_pc
);

    logic dmem_access;
    logic branch_jump;
    logic wait_for_imem;
    logic wait_for_dmem;
    logic rs1_match;
    logic rs2_match;
    logic cannot_forward;
    logic exception;
    logic intr_gated;        // Interrupt with no exception pending
    logic ex_flush_hazard;

    // Data hazards, x0 never matches
    assign rs1_match      = (rs1_e == rd_m) && (rd_m != '0);
    assign rs2_match      = (rs2_e == rd_m) && (rd_m != '0);
    assign cannot_forward = dren || csr_read;  // Result only known at end of M
    assign mem_use_stall  = reg_write_m && cannot_forward && (rs1_match || rs2_match);

    assign dmem_access = dren || dwen;
    assign branch_jump = jump || (branch && mispredict);
    assign npc_sel     = branch_jump;

    // Fetch-side faults belong to a squashed path on a redirect
    always_comb begin
        exc_masked = exc_flags;
        exc_masked[EXC_FAULT_INSN] = exc_flags[EXC_FAULT_INSN] && !branch_jump;
        exc_masked[EXC_MAL_INSN]   = exc_flags[EXC_MAL_INSN] && !branch_jump;
    end

    assign exception  = |exc_masked;
    assign intr_gated = intr && !exception;

    // Memory waits, dropped when the request is being killed anyway
    assign wait_for_imem = i_mem_busy && !suppress_iren;
    assign wait_for_dmem = dmem_access && d_mem_busy && !suppress_data;

    // Interrupt lets a pending data access finish first
    assign ex_flush_hazard = ((intr_gated || exception) && !wait_for_dmem)
                           || exception
                           || mret
                           || rollback;

    assign rollback      = ifence && !fence_stall;  // Refetch after I-fence completes
    assign suppress_iren = branch_jump || ex_flush_hazard || mret || insert_pc;
    assign suppress_data = exception;               // Keep faulting access off the bus

    // Redirect passes straight on to fetch
    assign insert_priv_pc = insert_pc;
    assign priv_pc        = priv_pc_in;

    // Oldest valid instruction, interrupts retire M first
    assign epc = (valid_m && (!intr_gated || branch_jump)) ? pc_m :
                 (valid_e ? pc_e : pc_f);
    assign badaddr   = fault_addr;
    assign wb_enable = !if_ex_stall || jump || branch;  // Two stages behind fetch

    // Later stage stall always stalls earlier stage
    assign ex_mem_stall = wait_for_dmem || fence_stall || halt;

    assign if_ex_stall = !intr_gated
                       && (ex_mem_stall
                       || (ex_busy && !ex_flush_hazard && !branch_jump)  // Redirect beats busy E
                       || mem_use_stall
                       || fence_stall);

    assign if_ex_flush = ex_flush_hazard
                       || branch_jump
                       || (wait_for_imem && !ex_mem_stall);  // Bubble while fetch lags

    // Bubble into M when E is held but M moves on
    assign ex_mem_flush = ex_flush_hazard
                        || branch_jump
                        || (if_ex_stall && !ex_mem_stall);

    // PC moves when fetch can hand off, or on any redirect
    assign pc_en = (!if_ex_stall && !wait_for_imem)
                 || branch_jump
                 || ex_flush_hazard
                 || insert_pc
                 || mret;

endmodule

//--- priv/priv_trap_unit.sv
// ======================================
// Machine-mode trap entry and mret
// mepc, mcause, mtval, mie, mpie
// ======================================

`timescale 1ns/1ps

module priv_trap_unit
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [EXC_COUNT-1:0] exc_masked,
    input  logic                 ext_irq,
    input  logic                 irq_enable,   // Level, sets mie
    input  logic                 mret,
    input  logic                 wb_enable,
    input  word_t                epc,
    input  word_t                badaddr,
    output logic                 intr,
    output logic                 insert_pc,
    output word_t                priv_pc,
    output word_t                mepc,
    output word_t                mcause,
    output word_t                mtval
);

    logic   exc_any;
    logic   trap_taken;
    logic   mie;
    logic   mpie;
    cause_t exc_code;
    word_t  trap_cause;
    word_t  trap_tval;

    assign exc_any    = |exc_masked;
    assign intr       = ext_irq && mie && !exc_any;  // Exceptions take precedence
    assign trap_taken = (exc_any || intr) && wb_enable;

    // Redirect on trap entry or return, trap wins
    assign insert_pc = trap_taken || mret;
    assign priv_pc   = trap_taken ? TRAP_VECTOR : mepc;

    // Highest set flag, scan upwards so the top index wins
    always_comb begin
        exc_code = CAUSE_ILLEGAL;
        for (int i = 0; i < EXC_COUNT; i++) begin
            if (exc_masked[i]) begin
                exc_code = exc_cause(i);
            end
        end
    end

    always_comb begin
        trap_cause = '0;
        if (intr) begin
            trap_cause[MCAUSE_IRQ_B]  = 1'b1;
            trap_cause[CAUSE_W-1:0]   = IRQ_EXT_CAUSE;
        end else begin
            trap_cause[CAUSE_W-1:0]   = exc_code;
        end
    end

    // Address faults report the address, everything else zero
    assign trap_tval = (exc_any && is_addr_fault(exc_code)) ? badaddr : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
            mie    <= 1'b0;
            mpie   <= 1'b0;
        end else if (trap_taken) begin
            mepc   <= epc;
            mcause <= trap_cause;
            mtval  <= trap_tval;
            mpie   <= mie;    // Stack the enable
            mie    <= 1'b0;   // No nesting
        end else if (mret) begin
            mie    <= mpie;
            mpie   <= 1'b1;
        end else if (irq_enable) begin
            mie    <= 1'b1;
        end
    end

    // mie drops on entry, so a repeat redirect needs a new cause
    a_no_double_trap: assert property (@(posedge clk) disable iff (!arst_n)
        trap_taken |=> (!insert_pc || exc_any || mret))
        else $error("Redirect repeated without a new trap cause");

endmodule

//--- logic/pc_chain.sv
// ======================================
// Fetch PC register
// E and M stage PC and valid registers
// ======================================

`timescale 1ns/1ps

module pc_chain
    import rv32i_types_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  pc_en,
    input  logic  npc_sel,
    input  logic  insert_pc,
    input  logic  if_ex_stall,
    input  logic  if_ex_flush,
    input  logic  ex_mem_stall,
    input  logic  ex_mem_flush,
    input  logic  i_mem_busy,
    input  word_t branch_target,
    input  word_t priv_pc,
    output word_t pc_f,
    output word_t pc_e,
    output word_t pc_m,
    output logic  valid_e,
    output logic  valid_m
);

    word_t npc;

    // Trap/mret first, then branch, then sequential
    assign npc = insert_pc ? priv_pc :
                 (npc_sel  ? branch_target : pc_f + word_t'(PC_STEP));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_f <= RESET_PC;
        end else if (pc_en) begin
            pc_f <= npc;
        end
    end

    // Valid bits, flush beats stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_e <= 1'b0;
            valid_m <= 1'b0;
        end else begin
            if (if_ex_flush) begin
                valid_e <= 1'b0;
            end else if (!if_ex_stall) begin
                valid_e <= !i_mem_busy;    // No instruction yet while fetch waits
            end
            if (ex_mem_flush) begin
                valid_m <= 1'b0;
            end else if (!ex_mem_stall) begin
                valid_m <= valid_e;
            end
        end
    end

    // Stage PCs follow their valid bits
    always_ff @(posedge clk) begin
        if (!if_ex_stall) begin
            pc_e <= pc_f;
        end
        if (!ex_mem_stall) begin
            pc_m <= pc_e;
        end
    end

    // A bubble made at F/E must arrive in M as a bubble
    a_bubble_reaches_m: assert property (@(posedge clk) disable iff (!arst_n)
        if_ex_flush ##1 (!ex_mem_stall && !ex_mem_flush) |=> !valid_m)
        else $error("Flushed slot became valid in M");

endmodule

//--- logic/pipe_ctrl_top.sv
// ======================================
// Pipeline control top level
// Hazard unit, trap unit and PC chain
// ======================================

`timescale 1ns/1ps

module pipe_ctrl_top
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  regidx_t              rs1_e,
    input  regidx_t              rs2_e,
    input  regidx_t              rd_m,
    input  logic                 reg_write_m,
    input  logic                 dren,
    input  logic                 dwen,
    input  logic                 csr_read,
    input  logic                 jump,
    input  logic                 branch,
    input  logic                 mispredict,
    input  word_t                branch_target,
    input  logic                 i_mem_busy,
    input  logic                 d_mem_busy,
    input  logic                 ex_busy,
    input  logic                 ifence,
    input  logic                 fence_stall,
    input  logic                 halt,
    input  logic                 mret,
    input  logic [EXC_COUNT-1:0] exc_flags,
    input  word_t                fault_addr,
    input  logic                 ext_irq,
    input  logic                 irq_enable,
    output word_t                pc_f,
    output word_t                pc_e,
    output word_t                pc_m,
    output logic                 valid_e,
    output logic                 valid_m,
    output logic                 if_ex_stall,
    output logic                 if_ex_flush,
    output logic                 ex_mem_stall,
    output logic                 ex_mem_flush,
    output logic                 suppress_iren,
    output logic                 suppress_data,
    output logic                 rollback,
    output logic                 insert_pc,
    output word_t                mepc,
    output word_t                mcause,
    output word_t                mtval
);

    logic                 pc_en;
    logic                 npc_sel;
    logic                 intr;
    logic                 wb_enable;
    logic                 insert_priv_pc;
    logic [EXC_COUNT-1:0] exc_masked;
    word_t                epc;
    word_t                badaddr;
    word_t                priv_pc;       // Forwarded by hazard unit
    word_t                priv_pc_trap;  // Straight from trap unit

    stage3_hazard_unit u_hazard (
        .priv_pc_in    (priv_pc_trap),
        .mem_use_stall (),               // Folded into if_ex_stall
        .*
    );

    priv_trap_unit u_priv (
        .priv_pc (priv_pc_trap),
        .*
    );

    pc_chain u_pc_chain (
        .insert_pc (insert_priv_pc),
        .*
    );

endmodule

//--- testbench/tb_pipe_ctrl_model.svh
// ========================================
// Reference model of the pipeline controls
// Hazard terms, trap CSRs and the PC chain
// ========================================

`ifndef TB_PIPE_CTRL_MODEL_SVH
`define TB_PIPE_CTRL_MODEL_SVH

// Model state, one per DUT register
word_t m_pc_f, m_pc_e, m_pc_m, m_mepc, m_mcause, m_mtval;
logic  m_valid_e, m_valid_m, m_mie, m_mpie;

// Expected combinational outputs
logic  x_if_ex_stall, x_if_ex_flush, x_ex_mem_stall, x_ex_mem_flush;
logic  x_suppress_iren, x_suppress_data, x_rollback, x_insert_pc;

// Internal terms of the current cycle
logic  redirect, exc_seen, irq, flush_hz, wait_d, wait_i, use_hz, wb_ok, trap, pc_move;
logic [EXC_COUNT-1:0] live_flags;
word_t next_pc, trap_epc;

// Architectural code of the highest-priority flag
function automatic logic [3:0] top_cause(input logic [EXC_COUNT-1:0] f);
    if (f[EXC_BREAKPOINT]) return 4'd3;
    if (f[EXC_FAULT_INSN]) return 4'd1;
    if (f[EXC_MAL_INSN])   return 4'd0;
    if (f[EXC_ILLEGAL])    return 4'd2;
    if (f[EXC_ENV])        return 4'd11;  // ecall from M
    if (f[EXC_MAL_S])      return 4'd6;
    if (f[EXC_MAL_L])      return 4'd4;
    if (f[EXC_FAULT_S])    return 4'd7;
    return 4'd5;                          // Load access fault
endfunction

// Misaligned and access faults carry the address in mtval
function automatic logic reports_address(input logic [3:0] c);
    return c inside {4'd0, 4'd1, 4'd4, 4'd5, 4'd6, 4'd7};
endfunction

task automatic reset_state();
    m_pc_f    = RESET_PC;
    m_pc_e    = RESET_PC;    // Stage PCs keep loading fetch PC during reset
    m_pc_m    = RESET_PC;
    m_valid_e = 1'b0;
    m_valid_m = 1'b0;
    m_mepc    = '0;
    m_mcause  = '0;
    m_mtval   = '0;
    m_mie     = 1'b0;
    m_mpie    = 1'b0;
endtask

// Hazard equations from the current inputs and model state
task automatic comb_outputs();
    redirect   = jump || (branch && mispredict);
    live_flags = exc_flags;
    if (redirect) begin
        live_flags[EXC_FAULT_INSN] = 1'b0;  // Wrong-path fetch faults
        live_flags[EXC_MAL_INSN]   = 1'b0;
    end
    exc_seen = |live_flags;
    irq      = ext_irq && m_mie && !exc_seen;
    use_hz   = reg_write_m && (dren || csr_read) && (rd_m != '0)
             && ((rs1_e == rd_m) || (rs2_e == rd_m));
    x_rollback      = ifence && !fence_stall;
    wait_d          = (dren || dwen) && d_mem_busy && !exc_seen;
    flush_hz        = (irq && !wait_d) || exc_seen || mret || x_rollback;
    x_ex_mem_stall  = wait_d || fence_stall || halt;
    x_if_ex_stall   = !irq && (x_ex_mem_stall || use_hz || (ex_busy && !flush_hz && !redirect));
    wb_ok           = !x_if_ex_stall || jump || branch;
    trap            = (exc_seen || irq) && wb_ok;
    x_insert_pc     = trap || mret;
    x_suppress_iren = redirect || flush_hz || x_insert_pc;
    x_suppress_data = exc_seen;
    wait_i          = i_mem_busy && !x_suppress_iren;
    x_if_ex_flush   = flush_hz || redirect || (wait_i && !x_ex_mem_stall);
    x_ex_mem_flush  = flush_hz || redirect || (x_if_ex_stall && !x_ex_mem_stall);
    pc_move         = (!x_if_ex_stall && !wait_i) || x_suppress_iren;
    next_pc  = trap ? TRAP_VECTOR : (mret ? m_mepc : (redirect ? branch_target : m_pc_f + 32'd4));
    trap_epc = (m_valid_m && (!irq || redirect)) ? m_pc_m : (m_valid_e ? m_pc_e : m_pc_f);
endtask

// Register updates at the rising edge, oldest stage first
task automatic clock_edge_update();
    if (trap) begin
        m_mepc   = trap_epc;
        m_mcause = irq ? 32'h8000_000b : {28'd0, top_cause(live_flags)};
        m_mtval  = (!irq && reports_address(top_cause(live_flags))) ? fault_addr : '0;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
    end else if (mret) begin
        m_mie    = m_mpie;
        m_mpie   = 1'b1;
    end else if (irq_enable) begin
        m_mie    = 1'b1;
    end
    if (x_ex_mem_flush) begin
        m_valid_m = 1'b0;
    end else if (!x_ex_mem_stall) begin
        m_valid_m = m_valid_e;
    end
    if (!x_ex_mem_stall) begin
        m_pc_m = m_pc_e;
    end
    if (x_if_ex_flush) begin
        m_valid_e = 1'b0;
    end else if (!x_if_ex_stall) begin
        m_valid_e = !i_mem_busy;
    end
    if (!x_if_ex_stall) begin
        m_pc_e = m_pc_f;
    end
    if (pc_move) begin
        m_pc_f = next_pc;
    end
endtask

`endif

//--- testbench/tb_pipe_ctrl.sv
// ========================================
// Testbench for the pipeline control top
// Directed hazard, trap and irq sequences
// Random mix checked against the model
// ========================================

`timescale 1ns/1ps

module tb_pipe_ctrl
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;
();

    localparam int          RESET_CYCLES   = 16;
    localparam int          DIRECTED_MAX   = 300;   // Upper bound of the directed part
    localparam int          RANDOM_CYCLES  = 4000;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_MAX + RANDOM_CYCLES + 700;
    localparam logic [31:0] SEED           = 32'h93c7b378;

    logic clk;
    logic arst_n;
    regidx_t rs1_e, rs2_e, rd_m;
    logic reg_write_m, dren, dwen, csr_read, jump, branch, mispredict;
    logic i_mem_busy, d_mem_busy, ex_busy, ifence, fence_stall, halt, mret;
    logic ext_irq, irq_enable;
    logic [EXC_COUNT-1:0] exc_flags;
    word_t branch_target, fault_addr;
    word_t pc_f, pc_e, pc_m, mepc, mcause, mtval;
    logic valid_e, valid_m, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush;
    logic suppress_iren, suppress_data, rollback, insert_pc;

    logic [31:0] lfsr;
    int          cycles;

    pipe_ctrl_top dut (.*);

    `include "tb_pipe_ctrl_model.svh"

    always #10 clk = ~clk;   // 20 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence never finished", cycles);
            $display("Some tests failed");
            $fatal(1, "Simulation timed out");
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // AND of n fresh bits, so 1 in 2**n
    function automatic logic rare_bit(input int n);
        return draw(n) == ((32'd1 << n) - 32'd1);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            $display("Some tests failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic compare_outputs();
        check_val("pc_f", pc_f, m_pc_f);
        check_val("pc_e", pc_e, m_pc_e);
        check_val("pc_m", pc_m, m_pc_m);
        check_val("valid_e", valid_e, m_valid_e);
        check_val("valid_m", valid_m, m_valid_m);
        check_val("if_ex_stall", if_ex_stall, x_if_ex_stall);
        check_val("if_ex_flush", if_ex_flush, x_if_ex_flush);
        check_val("ex_mem_stall", ex_mem_stall, x_ex_mem_stall);
        check_val("ex_mem_flush", ex_mem_flush, x_ex_mem_flush);
        check_val("suppress_iren", suppress_iren, x_suppress_iren);
        check_val("suppress_data", suppress_data, x_suppress_data);
        check_val("rollback", rollback, x_rollback);
        check_val("insert_pc", insert_pc, x_insert_pc);
        check_val("mepc", mepc, m_mepc);
        check_val("mcause", mcause, m_mcause);
        check_val("mtval", mtval, m_mtval);
    endtask

    task automatic idle_inputs();
        {rs1_e, rs2_e, rd_m} = '0;
        {reg_write_m, dren, dwen, csr_read, jump, branch, mispredict} = '0;
        {i_mem_busy, d_mem_busy, ex_busy, ifence, fence_stall, halt, mret} = '0;
        {ext_irq, irq_enable} = '0;
        exc_flags     = '0;
        branch_target = '0;
        fault_addr    = '0;
    endtask

    task automatic random_inputs();
        rs1_e         = regidx_t'(draw(2));   // Narrow range, so matches and x0 occur
        rs2_e         = regidx_t'(draw(2));
        rd_m          = regidx_t'(draw(2));
        reg_write_m   = rare_bit(1);
        dren          = rare_bit(1);
        dwen          = rare_bit(2);
        csr_read      = rare_bit(3);
        jump          = rare_bit(3);
        branch        = rare_bit(1);
        mispredict    = rare_bit(2);
        branch_target = draw(32) & 32'h0000_fffc;
        i_mem_busy    = rare_bit(2);
        d_mem_busy    = rare_bit(2);
        ex_busy       = rare_bit(3);
        ifence        = rare_bit(4);
        fence_stall   = rare_bit(3);
        halt          = rare_bit(4);
        mret          = rare_bit(5);
        exc_flags     = rare_bit(3) ? EXC_COUNT'(draw(EXC_COUNT)) : '0;
        fault_addr    = draw(32);
        ext_irq       = rare_bit(2);
        irq_enable    = rare_bit(3);
    endtask

    // Inputs are already set at the falling edge
    task automatic run_cycle();
        #2;
        comb_outputs();
        compare_outputs();
        clock_edge_update();
        @(negedge clk);
    endtask

    initial begin
        word_t                held_f, held_e, held_m;
        logic [EXC_COUNT-1:0] flags;
        clk    = 1'b0;
        arst_n = 1'b0;
        lfsr   = SEED;
        cycles = 0;
        idle_inputs();
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        reset_state();
        repeat (4) run_cycle();              // Fill E and M

        // Load in M feeds rs1 in E
        rd_m        = 5'd5;
        rs1_e       = 5'd5;
        reg_write_m = 1'b1;
        dren        = 1'b1;
        held_f      = pc_f;
        run_cycle();
        check_val("pc_f", pc_f, held_f);
        check_val("valid_m", valid_m, 1'b0);
        rd_m   = '0;                         // x0 never stalls
        rs1_e  = '0;
        held_f = pc_f;
        run_cycle();
        check_val("pc_f", pc_f, held_f + 32'd4);

        // Jump, then mispredicted branch
        idle_inputs();
        jump          = 1'b1;
        branch_target = 32'h0000_0400;
        run_cycle();
        check_val("pc_f", pc_f, 32'h0000_0400);
        check_val("valid_e", valid_e, 1'b0);
        jump          = 1'b0;
        branch        = 1'b1;
        mispredict    = 1'b1;
        branch_target = 32'h0000_0480;
        run_cycle();
        check_val("pc_f", pc_f, 32'h0000_0480);

        // Data wait, halt and fence each freeze the pipe
        for (int k = 0; k < 3; k++) begin
            idle_inputs();
            repeat (2) run_cycle();
            dren        = (k == 0);
            d_mem_busy  = (k == 0);
            halt        = (k == 1);
            fence_stall = (k == 2);
            held_f      = pc_f;
            held_e      = pc_e;
            held_m      = pc_m;
            repeat (5) begin
                run_cycle();
                check_val("pc_f", pc_f, held_f);
                check_val("pc_e", pc_e, held_e);
                check_val("pc_m", pc_m, held_m);
            end
        end
        fence_stall = 1'b0;
        ifence      = 1'b1;                  // Fence done, refetch
        run_cycle();
        check_val("valid_e", valid_e, 1'b0);

        // Exception flag sets with varying stage occupancy
        repeat (40) begin
            idle_inputs();
            i_mem_busy = rare_bit(1);
            repeat (2) run_cycle();
            i_mem_busy = 1'b0;
            flags      = EXC_COUNT'(draw(EXC_COUNT));
            exc_flags  = (flags == '0) ? EXC_COUNT'(1) : flags;
            fault_addr = draw(32);
            run_cycle();
            check_val("pc_f", pc_f, TRAP_VECTOR);
        end

        // External interrupt, masked then enabled, then mret
        idle_inputs();
        ext_irq = 1'b1;
        held_f  = pc_f;
        run_cycle();
        check_val("pc_f", pc_f, held_f + 32'd4);
        ext_irq    = 1'b0;
        irq_enable = 1'b1;
        run_cycle();
        irq_enable = 1'b0;
        ext_irq    = 1'b1;
        run_cycle();
        check_val("mcause", mcause, 32'h8000_000b);
        check_val("pc_f", pc_f, TRAP_VECTOR);
        run_cycle();                         // Held irq ignored, mie cleared on entry
        check_val("pc_f", pc_f, TRAP_VECTOR + 32'd4);
        ext_irq = 1'b0;
        mret    = 1'b1;
        run_cycle();
        check_val("pc_f", pc_f, m_mepc);
        mret    = 1'b0;
        ext_irq = 1'b1;                      // Traps again only if mie came back
        run_cycle();
        check_val("pc_f", pc_f, TRAP_VECTOR);

        repeat (RANDOM_CYCLES) begin
            random_inputs();
            run_cycle();
        end
        $display("All tests passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+testbench
common/rv32i_types_pkg.sv
common/pipe_ctrl_pkg.sv
hazard/stage3_hazard_unit.sv
priv/priv_trap_unit.sv
logic/pc_chain.sv
logic/pipe_ctrl_top.sv
testbench/tb_pipe_ctrl.sv

//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - files:
      - common/rv32i_types_pkg.sv
      - common/pipe_ctrl_pkg.sv
      - hazard/stage3_hazard_unit.sv
      - priv/priv_trap_unit.sv
      - logic/pc_chain.sv
      - logic/pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_pipe_ctrl.sv
